// File: src/class_switch_cfg.svh
////////////////////////////////////////
// class switch sizes and thresholds
// word width, fifo depth, flag levels
////////////////////////////////////////

`ifndef CLASS_SWITCH_CFG_SVH
`define CLASS_SWITCH_CFG_SVH

// data word, msb carries the class
`define CS_DATA_W     10

// entries per class fifo, power of two
`define CS_FIFO_DEPTH 8

// status flag levels, compared to occupancy
`define CS_AF_LEVEL   6  // almost_full at or above
`define CS_AE_LEVEL   2  // almost_empty at or below

`endif

// File: src/class_switch_pkg.sv
////////////////////////////////////////
// class switch shared types
// data word, fifo status, output lane
////////////////////////////////////////

`default_nettype none

`include "class_switch_cfg.svh"

package class_switch_pkg;

  // one data word, class in the msb
  typedef struct packed {
    logic                   cls;      // 0 or 1, selects fifo
    logic [`CS_DATA_W-2:0]  payload;  // carried unchanged
  } cs_word_t;

  // flags reported by each class fifo
  typedef struct packed {
    logic empty;         // count == 0
    logic full;          // count == depth
    logic almost_full;   // count >= af level
    logic almost_empty;  // count <= ae level
    logic overflow;      // push refused, one cycle
  } fifo_status_t;

  // one output lane toward downstream
  typedef struct packed {
    logic     valid;  // one cycle per word
    cs_word_t word;
  } lane_t;

endpackage

`default_nettype wire

// File: src/class_demux.sv
////////////////////////////////////////
// class demux
// captures strobed words, then raises a
// one-hot push for the word's class
////////////////////////////////////////

`default_nettype none

module class_demux (
  input  logic                       clk,
  input  logic                       rst_n,
  input  class_switch_pkg::cs_word_t in_word,
  input  logic                       valid_in,   // single cycle, no back-pressure
  output class_switch_pkg::cs_word_t word,       // to both fifos
  output logic [1:0]                 push        // one-hot by class
);

  class_switch_pkg::cs_word_t in_word_q;  // capture stage
  logic                       in_valid_q;

  ////////////////////////////////////////
  // input capture
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= valid_in;  // strobe follows word
    end
  end

  always_ff @(posedge clk) begin
    if (valid_in) begin
      in_word_q <= in_word;  // hold payload only when strobed
    end
  end

  ////////////////////////////////////////
  // class decode
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push <= 2'b00;
    end else if (in_valid_q) begin
      push <= in_word_q.cls ? 2'b10 : 2'b01;  // only own class fifo
    end else begin
      push <= 2'b00;
    end
  end

  always_ff @(posedge clk) begin
    word <= in_word_q;  // lines up with push
  end

endmodule

`default_nettype wire

// File: src/class_fifo.sv
////////////////////////////////////////
// class fifo
// circular buffer for one class, with
// occupancy flags and overflow pulse
////////////////////////////////////////

`default_nettype none

`include "class_switch_cfg.svh"

module class_fifo #(
  parameter int DEPTH = `CS_FIFO_DEPTH  // power of two
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           push,     // from demux
  input  logic                           pop,      // from flow control
  input  class_switch_pkg::cs_word_t     wr_word,
  output class_switch_pkg::cs_word_t     rd_word,  // registered on pop
  output class_switch_pkg::fifo_status_t status
);

  localparam int AW = $clog2(DEPTH);  // pointer width
  localparam int CW = AW + 1;         // count reaches DEPTH

  class_switch_pkg::cs_word_t mem [DEPTH];  // storage

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;   // occupancy
  logic          wr_en;
  logic          rd_en;
  logic          is_full;
  logic          is_empty;

  ////////////////////////////////////////
  // accept and release
  ////////////////////////////////////////
  assign is_full  = (count == CW'(DEPTH));
  assign is_empty = (count == '0);
  assign wr_en    = push & ~is_full;  // push on full is dropped
  assign rd_en    = pop;              // pop while empty is a checker error

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + AW'(1);  // wraps at depth
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
    end
  end

  // occupancy, push and pop together cancel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_word <= mem[rd_ptr];  // head word, one cycle after pop
    end
  end

  ////////////////////////////////////////
  // status flags
  ////////////////////////////////////////
  always_comb begin
    status.empty        = is_empty;
    status.full         = is_full;
    status.almost_full  = (count >= CW'(`CS_AF_LEVEL));
    status.almost_empty = (count <= CW'(`CS_AE_LEVEL));
    status.overflow     = push & is_full;  // dropped word
  end

endmodule

`default_nettype wire

// File: src/flow_ctrl.sv
////////////////////////////////////////
// flow control
// pops each class under back-pressure,
// forms lanes, holds the sticky error
////////////////////////////////////////

`default_nettype none

module flow_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  class_switch_pkg::fifo_status_t status0,
  input  class_switch_pkg::fifo_status_t status1,
  input  class_switch_pkg::cs_word_t     rd_word0,
  input  class_switch_pkg::cs_word_t     rd_word1,
  input  logic [1:0]                     full_down,  // downstream full, per class
  output logic [1:0]                     pop,
  output class_switch_pkg::lane_t        out0,
  output class_switch_pkg::lane_t        out1,
  output logic [1:0]                     af_up,
  output logic [1:0]                     full_up,
  output logic [1:0]                     ae_down,
  output logic                           error
);

  logic [1:0] empty_v;   // per class, bit = class
  logic [1:0] ovf_v;
  logic [1:0] pop_q;     // pop delayed to meet rd_word

  assign empty_v = {status1.empty, status0.empty};
  assign ovf_v   = {status1.overflow, status0.overflow};

  ////////////////////////////////////////
  // pop issue
  ////////////////////////////////////////
  // one word per cycle while data and room downstream
  assign pop = ~empty_v & ~full_down;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_q <= 2'b00;
    end else begin
      pop_q <= pop;  // head word registers on same edge
    end
  end

  ////////////////////////////////////////
  // output lanes
  ////////////////////////////////////////
  always_comb begin
    out0.valid = pop_q[0];
    out0.word  = rd_word0;
    out1.valid = pop_q[1];
    out1.word  = rd_word1;
  end

  // status toward neighbours, bit = class
  assign af_up   = {status1.almost_full,  status0.almost_full};
  assign full_up = {status1.full,         status0.full};
  assign ae_down = {status1.almost_empty, status0.almost_empty};

  ////////////////////////////////////////
  // sticky error
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error <= 1'b0;
    end else if (|ovf_v) begin
      error <= 1'b1;  // only reset clears it
    end
  end

endmodule

`default_nettype wire

// File: src/class_switch.sv
////////////////////////////////////////
// class switch layer
// demux into two class fifos, drained by
// flow control onto two output lanes
////////////////////////////////////////

`default_nettype none

module class_switch (
  input  logic                       clk,
  input  logic                       rst_n,
  input  class_switch_pkg::cs_word_t in_word,
  input  logic                       valid_in,   // no back-pressure upstream
  input  logic [1:0]                 full_down,  // per class lane
  output class_switch_pkg::lane_t    out0,       // class 0 words
  output class_switch_pkg::lane_t    out1,       // class 1 words
  output logic [1:0]                 af_up,
  output logic [1:0]                 full_up,
  output logic [1:0]                 ae_down,
  output logic                       error       // sticky overflow
);

  class_switch_pkg::cs_word_t     word;      // demux to fifos
  logic [1:0]                     push;      // one-hot by class
  logic [1:0]                     pop;       // flow control to fifos
  class_switch_pkg::cs_word_t     rd_word0;
  class_switch_pkg::cs_word_t     rd_word1;
  class_switch_pkg::fifo_status_t status0;
  class_switch_pkg::fifo_status_t status1;

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////
  class_demux u_demux (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_word  (in_word),
    .valid_in (valid_in),
    .word     (word),
    .push     (push)
  );

  ////////////////////////////////////////
  // per class storage
  ////////////////////////////////////////
  class_fifo u_fifo0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (push[0]),
    .pop     (pop[0]),
    .wr_word (word),
    .rd_word (rd_word0),
    .status  (status0)
  );

  class_fifo u_fifo1 (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (push[1]),
    .pop     (pop[1]),
    .wr_word (word),
    .rd_word (rd_word1),
    .status  (status1)
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////
  flow_ctrl u_flow (
    .clk       (clk),
    .rst_n     (rst_n),
    .status0   (status0),
    .status1   (status1),
    .rd_word0  (rd_word0),
    .rd_word1  (rd_word1),
    .full_down (full_down),
    .pop       (pop),
    .out0      (out0),
    .out1      (out1),
    .af_up     (af_up),
    .full_up   (full_up),
    .ae_down   (ae_down),
    .error     (error)
  );

endmodule

`default_nettype wire

// File: dv/class_switch_chk.sv
////////////////////////////////////////
// class switch checker
// pop, lane and error rules, bound to
// the class switch top level
////////////////////////////////////////

`default_nettype none

module class_switch_chk (
  input logic                           clk,
  input logic                           rst_n,
  input logic [1:0]                     pop,        // flow control to fifos
  input logic [1:0]                     full_down,
  input class_switch_pkg::fifo_status_t status0,
  input class_switch_pkg::fifo_status_t status1,
  input class_switch_pkg::lane_t        out0,
  input class_switch_pkg::lane_t        out1,
  input logic                           error
);
  timeunit 1ns;
  timeprecision 1ps;

  // never pop an empty fifo
  a_pop0_data: assert property (@(posedge clk) disable iff (!rst_n)
    pop[0] |-> !status0.empty) else $error("class 0 popped while its fifo was empty");
  a_pop1_data: assert property (@(posedge clk) disable iff (!rst_n)
    pop[1] |-> !status1.empty) else $error("class 1 popped while its fifo was empty");

  // lane valid is the pop, one cycle later
  a_lane0_pop: assert property (@(posedge clk) disable iff (!rst_n)
    out0.valid == $past(pop[0])) else $error("lane 0 valid not one cycle after a pop");
  a_lane1_pop: assert property (@(posedge clk) disable iff (!rst_n)
    out1.valid == $past(pop[1])) else $error("lane 1 valid not one cycle after a pop");

  // held lane stays quiet
  a_lane0_held: assert property (@(posedge clk) disable iff (!rst_n)
    out0.valid |-> !$past(full_down[0])) else $error("lane 0 valid after a held cycle");
  a_lane1_held: assert property (@(posedge clk) disable iff (!rst_n)
    out1.valid |-> !$past(full_down[1])) else $error("lane 1 valid after a held cycle");

  // sticky until reset
  a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    error |=> error) else $error("error flag fell without reset");

endmodule

bind class_switch class_switch_chk i_chk (
  .clk(clk), .rst_n(rst_n), .pop(pop), .full_down(full_down), .status0(status0),
  .status1(status1), .out0(out0), .out1(out1), .error(error)
);

`default_nettype wire

// File: dv/class_switch_tb.sv
////////////////////////////////////////
// class switch testbench
// directed and random traffic, checked
// against per class expected queues
////////////////////////////////////////

`default_nettype none

`include "class_switch_cfg.svh"

module class_switch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PW         = `CS_DATA_W - 1;  // payload width
  localparam int MAX_CYCLES = 2000;            // tests need about 450
  localparam int WAIT_LIMIT = 40;              // per lane or drain wait
  localparam int RAND_LEN   = 300;

  logic                       clk;
  logic                       rst_n;
  class_switch_pkg::cs_word_t in_word;
  logic                       valid_in;
  logic [1:0]                 full_down;
  class_switch_pkg::lane_t    out0;
  class_switch_pkg::lane_t    out1;
  logic [1:0]                 af_up;
  logic [1:0]                 full_up;
  logic [1:0]                 ae_down;
  logic                       error;

  class_switch_pkg::cs_word_t exp_q0[$];  // words inside the layer, class 0
  class_switch_pkg::cs_word_t exp_q1[$];  // same for class 1
  int    out_cnt[2];  // lane valids seen
  int    cycle;       // rising edges so far
  int    errors;
  int    checks;
  int    seed;
  string test_name;

  class_switch i_dut (
    .clk(clk), .rst_n(rst_n), .in_word(in_word), .valid_in(valid_in),
    .full_down(full_down), .out0(out0), .out1(out1), .af_up(af_up),
    .full_up(full_up), .ae_down(ae_down), .error(error)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // run limit
  initial begin
    cycle = 0;
    while (cycle < MAX_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout: run passed %0d cycles with %0d errors", MAX_CYCLES, errors);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic compare_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  // lane monitor, outputs settled at the falling edge
  task automatic sample_lanes();
    class_switch_pkg::cs_word_t exp_w;
    if (out0.valid) begin
      out_cnt[0]++;
      if (exp_q0.size() == 0) begin
        report_fault("lane 0 delivered a word that was never expected");
      end else begin
        exp_w = exp_q0.pop_front();  // oldest class 0 word
        compare_val("lane 0 word", 32'(exp_w), 32'(out0.word));
      end
    end
    if (out1.valid) begin
      out_cnt[1]++;
      if (exp_q1.size() == 0) begin
        report_fault("lane 1 delivered a word that was never expected");
      end else begin
        exp_w = exp_q1.pop_front();
        compare_val("lane 1 word", 32'(exp_w), 32'(out1.word));
      end
    end
  endtask

  task automatic tick();
    @(negedge clk);  // drive point
    sample_lanes();
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    valid_in  = 1'b0;
    full_down = 2'b00;
    exp_q0.delete();
    exp_q1.delete();
    repeat (2) tick();  // two cycles in reset
    rst_n = 1'b1;
  endtask

  // strobe one word, kept words go to the expected queue
  task automatic send_word(input logic cls, input logic [PW-1:0] payload, input logic kept);
    in_word.cls     = cls;
    in_word.payload = payload;
    valid_in        = 1'b1;
    if (kept && cls) begin
      exp_q1.push_back(in_word);
    end else if (kept) begin
      exp_q0.push_back(in_word);
    end
    tick();
  endtask

  task automatic idle(input int n);
    valid_in = 1'b0;
    repeat (n) tick();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q0.size() + exp_q1.size() > 0 && n < WAIT_LIMIT) begin
      tick();
      n++;
    end
    if (exp_q0.size() + exp_q1.size() > 0) begin
      report_fault($sformatf("%0d words never left the layer", exp_q0.size() + exp_q1.size()));
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic reset_state();
    test_name = "reset";
    apply_reset();
    tick();
    compare_val("lane valids", 0, 32'({out1.valid, out0.valid}));
    compare_val("af_up", 0, 32'(af_up));
    compare_val("full_up", 0, 32'(full_up));
    compare_val("ae_down", 3, 32'(ae_down));  // both classes empty
    compare_val("error", 0, 32'(error));
  endtask

  task automatic route_one(input logic cls, input logic [PW-1:0] payload);
    int drive_cyc;
    int seen;
    int n;
    int base0;
    int base1;
    test_name = "routing";
    base0     = out_cnt[0];
    base1     = out_cnt[1];
    drive_cyc = cycle;  // next rising edge samples the word
    send_word(cls, payload, 1'b1);
    valid_in = 1'b0;
    seen     = -1;
    for (n = 0; n < WAIT_LIMIT && seen < 0; n++) begin
      tick();
      if (cls ? out1.valid : out0.valid) begin
        seen = cycle;
      end
    end
    if (seen < 0) begin
      report_fault("routed word never appeared on its own lane");
    end else begin
      compare_val("latency after sampling edge", 3, seen - drive_cyc - 1);
    end
    idle(4);
    compare_val("lane 0 count", cls ? 0 : 1, out_cnt[0] - base0);
    compare_val("lane 1 count", cls ? 1 : 0, out_cnt[1] - base1);
  endtask

  task automatic keep_order();
    logic [11:0] pattern;
    int          n;
    int          ones;
    int          base0;
    int          base1;
    test_name = "order";
    pattern   = 12'b1011_0010_1101;  // class per word, lsb first
    ones      = $countones(pattern);
    base0     = out_cnt[0];
    base1     = out_cnt[1];
    for (n = 0; n < 12; n++) begin
      send_word(pattern[0], PW'(n * 37 + 5), 1'b1);  // back to back
      pattern = pattern >> 1;
    end
    idle(1);
    wait_drain();
    compare_val("lane 0 count", 12 - ones, out_cnt[0] - base0);
    compare_val("lane 1 count", ones, out_cnt[1] - base1);
  endtask

  task automatic hold_class0();
    int n;
    int base0;
    int base1;
    test_name = "backpressure";
    base0     = out_cnt[0];
    base1     = out_cnt[1];
    full_down = 2'b01;  // lane 0 held
    for (n = 0; n < `CS_AF_LEVEL; n++) begin
      send_word(1'b0, PW'(n + 'h100), 1'b1);
      send_word(1'b1, PW'(n * 11), 1'b1);  // class 1 keeps moving
    end
    idle(6);
    compare_val("lane 0 count while held", 0, out_cnt[0] - base0);
    compare_val("lane 1 count while lane 0 held", `CS_AF_LEVEL, out_cnt[1] - base1);
    compare_val("af_up[0] while held", 1, 32'(af_up[0]));
    compare_val("ae_down[0] while held", 0, 32'(ae_down[0]));
    full_down = 2'b00;
    wait_drain();
    idle(4);
    compare_val("lane 0 count after release", `CS_AF_LEVEL, out_cnt[0] - base0);
    compare_val("af_up[0] after drain", 0, 32'(af_up[0]));
    compare_val("ae_down[0] after drain", 1, 32'(ae_down[0]));
  endtask

  task automatic overflow_class1();
    int n;
    int base1;
    test_name = "overflow";
    base1     = out_cnt[1];
    full_down = 2'b10;
    for (n = 0; n < `CS_FIFO_DEPTH; n++) begin
      send_word(1'b1, PW'(n * 3 + 1), 1'b1);
    end
    idle(5);
    compare_val("full_up[1] at depth", 1, 32'(full_up[1]));
    compare_val("af_up[1] at depth", 1, 32'(af_up[1]));
    compare_val("ae_down[1] at depth", 0, 32'(ae_down[1]));
    compare_val("error before overflow", 0, 32'(error));
    send_word(1'b1, PW'('h1ff), 1'b0);  // ninth word, dropped
    idle(5);
    compare_val("error after overflow", 1, 32'(error));
    full_down = 2'b00;
    wait_drain();
    idle(4);
    compare_val("lane 1 count after release", `CS_FIFO_DEPTH, out_cnt[1] - base1);
    compare_val("error after drain", 1, 32'(error));
  endtask

  // full_down only while fewer than 4 words of that class are inside
  task automatic random_traffic();
    int              n;
    logic            cls;
    logic [PW-1:0]   payload;
    test_name = "random";
    apply_reset();
    for (n = 0; n < RAND_LEN; n++) begin
      full_down[0] = (exp_q0.size() < 4) ? 1'($random(seed)) : 1'b0;
      full_down[1] = (exp_q1.size() < 4) ? 1'($random(seed)) : 1'b0;
      if (1'($random(seed))) begin
        cls     = 1'($random(seed));
        payload = PW'($random(seed));
        send_word(cls, payload, 1'b1);
      end else begin
        idle(1);
      end
    end
    full_down = 2'b00;
    idle(1);
    wait_drain();
    idle(4);
    compare_val("error after random traffic", 0, 32'(error));
  endtask

  initial begin
    seed      = 48421;
    errors    = 0;
    checks    = 0;
    out_cnt   = '{0, 0};
    rst_n     = 1'b0;
    in_word   = '0;
    valid_in  = 1'b0;
    full_down = 2'b00;
    reset_state();
    route_one(1'b0, PW'('h0a5));
    route_one(1'b1, PW'('h15a));
    keep_order();
    hold_class0();
    overflow_class1();
    random_traffic();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+src
src/class_switch_pkg.sv
src/class_demux.sv
src/class_fifo.sv
src/flow_ctrl.sv
src/class_switch.sv
dv/class_switch_chk.sv
dv/class_switch_tb.sv

// File: Makefile
# Verilator build and run of the class switch testbench

SIM := obj_dir/Vclass_switch_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

$(SIM): files.f $(wildcard src/*) $(wildcard dv/*)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module class_switch_tb -f files.f

test: $(SIM)
	./$(SIM) > sim.log 2>&1; rc=$$?; cat sim.log; \
	  if [ $$rc -ne 0 ] || grep -q "Simulation failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
